//--- hw/soc_pkg.sv
package soc_pkg;

    // Data cache of 1024 words, 32 bits each.
    localparam int WADDR_W = 10;

    typedef logic [31:0]        word_t;
    typedef logic [3:0]         wmask_t;
    typedef logic [WADDR_W-1:0] waddr_t;

    // One request on a fill, store or load port.
    // Low address bits pick the bank, the rest pick the row.
    typedef struct packed {
        logic   en;
        logic   we;
        wmask_t wmask;
        waddr_t addr;
        word_t  data;
    } cache_req_t;

    // AXI4-Lite side of the register block.
    typedef logic [3:0] axil_addr_t;
    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    localparam axil_addr_t REG_CTRL_ADDR    = 4'h0;
    localparam axil_addr_t REG_SCRATCH_ADDR = 4'h4;

    // Bit positions in the control register.
    localparam int CTRL_POWER_OFF_BIT = 0;
    localparam int CTRL_REBOOT_BIT    = 1;

endpackage

//--- hw/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
    parameter int DEPTH = 512
) (
    input  logic                     clk,
    input  logic                     re,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output soc_pkg::word_t           rdata,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  soc_pkg::wmask_t          wmask,
    input  soc_pkg::word_t           wdata
);
    import soc_pkg::*;

    word_t mem [DEPTH];

    // Read port holds its last word while re is low.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

    // Byte lanes are written only where the mask is set.
    // A read of the same row in this cycle still sees the old word.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < $bits(wmask_t); b++) begin
                if (wmask[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- hw/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter #(
    parameter int NUM_BANKS = 2,
    parameter int NUM_LOADS = 2
) (
    input  soc_pkg::cache_req_t fill_req,
    input  soc_pkg::cache_req_t store_req,
    input  soc_pkg::cache_req_t load_req [NUM_LOADS],

    output logic fill_ready,
    output logic store_ready,
    output logic load_ready [NUM_LOADS],

    output logic                                            bank_re    [NUM_BANKS],
    output logic [soc_pkg::WADDR_W-$clog2(NUM_BANKS)-1:0]  bank_raddr [NUM_BANKS],
    output logic                                            bank_we    [NUM_BANKS],
    output logic [soc_pkg::WADDR_W-$clog2(NUM_BANKS)-1:0]  bank_waddr [NUM_BANKS],
    output soc_pkg::wmask_t                                 bank_wmask [NUM_BANKS],
    output soc_pkg::word_t                                  bank_wdata [NUM_BANKS],

    output logic                         load_accept [NUM_LOADS],
    output logic [$clog2(NUM_BANKS)-1:0] load_bank   [NUM_LOADS]
);
    import soc_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);

    logic              fill_wr;
    logic              store_wr;
    logic [BANK_W-1:0] fill_bank;
    logic [BANK_W-1:0] store_bank;
    logic [NUM_BANKS-1:0] bank_taken;

    assign fill_wr    = fill_req.en && fill_req.we;
    assign store_wr   = store_req.en && store_req.we;
    assign fill_bank  = fill_req.addr[BANK_W-1:0];
    assign store_bank = store_req.addr[BANK_W-1:0];

    // The memory controller is never stalled.
    assign fill_ready = 1'b1;

    // Store loses its bank only to a fill in the same cycle.
    assign store_ready = !(fill_wr && fill_bank == store_bank);

    always_comb begin
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_we[b]    = 1'b0;
            bank_waddr[b] = '0;
            bank_wmask[b] = '0;
            bank_wdata[b] = '0;
        end

        if (store_wr && store_ready) begin
            bank_we[store_bank]    = 1'b1;
            bank_waddr[store_bank] = store_req.addr[WADDR_W-1:BANK_W];
            bank_wmask[store_bank] = store_req.wmask;
            bank_wdata[store_bank] = store_req.data;
        end

        if (fill_wr) begin
            bank_we[fill_bank]    = 1'b1;
            bank_waddr[fill_bank] = fill_req.addr[WADDR_W-1:BANK_W];
            bank_wmask[fill_bank] = fill_req.wmask;
            bank_wdata[fill_bank] = fill_req.data;
        end
    end

    // Lowest port first: each load claims its bank's read port if no
    // lower-numbered load got there before it.
    always_comb begin
        bank_taken = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            bank_re[b]    = 1'b0;
            bank_raddr[b] = '0;
        end

        for (int l = 0; l < NUM_LOADS; l++) begin
            load_bank[l]   = load_req[l].addr[BANK_W-1:0];
            load_ready[l]  = !bank_taken[load_bank[l]];
            load_accept[l] = load_req[l].en && load_ready[l];
            if (load_accept[l]) begin
                bank_taken[load_bank[l]] = 1'b1;
                bank_re[load_bank[l]]    = 1'b1;
                bank_raddr[load_bank[l]] = load_req[l].addr[WADDR_W-1:BANK_W];
            end
        end
    end

endmodule

//--- hw/load_align.sv
`timescale 1ns/1ps

module load_align #(
    parameter int NUM_BANKS = 2,
    parameter int NUM_LOADS = 2
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load_accept [NUM_LOADS],
    input  logic [$clog2(NUM_BANKS)-1:0] load_bank   [NUM_LOADS],
    input  soc_pkg::word_t               bank_rdata  [NUM_BANKS],
    output soc_pkg::word_t               load_rdata  [NUM_LOADS],
    output logic                         load_rvalid [NUM_LOADS]
);
    localparam int BANK_W = $clog2(NUM_BANKS);

    // Bank each port read from in the previous cycle.
    logic [BANK_W-1:0] bank_q [NUM_LOADS];

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LOADS; l++) begin
            if (load_accept[l]) begin
                bank_q[l] <= load_bank[l];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int l = 0; l < NUM_LOADS; l++) begin
                load_rvalid[l] <= 1'b0;
            end
        end else begin
            for (int l = 0; l < NUM_LOADS; l++) begin
                load_rvalid[l] <= load_accept[l];
            end
        end
    end

    // Bank output is registered, so it lines up with the delayed index.
    always_comb begin
        for (int l = 0; l < NUM_LOADS; l++) begin
            load_rdata[l] = bank_rdata[bank_q[l]];
        end
    end

endmodule

//--- hw/mmio_regs.sv
`timescale 1ns/1ps

module mmio_regs (
    input  logic                clk,
    input  logic                reset,

    input  soc_pkg::axil_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,

    input  soc_pkg::word_t      wdata,
    input  soc_pkg::wmask_t     wstrb,
    input  logic                wvalid,
    output logic                wready,

    output soc_pkg::axil_resp_t bresp,
    output logic                bvalid,
    input  logic                bready,

    input  soc_pkg::axil_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,

    output soc_pkg::word_t      rdata,
    output soc_pkg::axil_resp_t rresp,
    output logic                rvalid,
    input  logic                rready,

    output logic                power_off,
    output logic                reboot
);
    import soc_pkg::*;

    logic  wr_fire;
    logic  rd_fire;
    logic  wr_ctrl;
    logic  wr_scratch;
    word_t scratch;

    // Address and data are taken together, and only with no response pending.
    assign awready = wvalid && !bvalid;
    assign wready  = awvalid && !bvalid;
    assign wr_fire = awvalid && wvalid && !bvalid;

    assign arready = !rvalid;
    assign rd_fire = arvalid && arready;

    assign wr_ctrl    = wr_fire && awaddr == REG_CTRL_ADDR;
    assign wr_scratch = wr_fire && awaddr == REG_SCRATCH_ADDR;

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid    <= 1'b0;
            power_off <= 1'b0;
            reboot    <= 1'b0;
            scratch   <= '0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            // Power-off is sticky; reboot lasts one cycle.
            reboot <= wr_ctrl && wstrb[0] && wdata[CTRL_REBOOT_BIT];
            if (wr_ctrl && wstrb[0] && wdata[CTRL_POWER_OFF_BIT]) begin
                power_off <= 1'b1;
            end

            if (wr_scratch) begin
                for (int b = 0; b < $bits(wmask_t); b++) begin
                    if (wstrb[b]) begin
                        scratch[8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= (wr_ctrl || wr_scratch) ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            case (araddr)
                REG_CTRL_ADDR: begin
                    rdata <= word_t'(power_off);
                    rresp <= RESP_OKAY;
                end
                REG_SCRATCH_ADDR: begin
                    rdata <= scratch;
                    rresp <= RESP_OKAY;
                end
                default: begin
                    rdata <= '0;
                    rresp <= RESP_SLVERR;
                end
            endcase
        end
    end

endmodule

//--- hw/soc_memory.sv
`timescale 1ns/1ps

module soc_memory #(
    parameter int NUM_BANKS = 2,
    parameter int NUM_LOADS = 2
) (
    input  logic                clk,
    input  logic                reset,

    input  soc_pkg::cache_req_t fill_req,
    output logic                fill_ready,
    input  soc_pkg::cache_req_t store_req,
    output logic                store_ready,
    input  soc_pkg::cache_req_t load_req    [NUM_LOADS],
    output logic                load_ready  [NUM_LOADS],
    output soc_pkg::word_t      load_rdata  [NUM_LOADS],
    output logic                load_rvalid [NUM_LOADS],

    input  soc_pkg::axil_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  soc_pkg::word_t      wdata,
    input  soc_pkg::wmask_t     wstrb,
    input  logic                wvalid,
    output logic                wready,
    output soc_pkg::axil_resp_t bresp,
    output logic                bvalid,
    input  logic                bready,
    input  soc_pkg::axil_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output soc_pkg::word_t      rdata,
    output soc_pkg::axil_resp_t rresp,
    output logic                rvalid,
    input  logic                rready,

    output logic                power_off,
    output logic                reboot
);
    import soc_pkg::*;

    localparam int BANK_W = $clog2(NUM_BANKS);
    localparam int DEPTH  = (1 << WADDR_W) / NUM_BANKS;
    localparam int ROW_W  = $clog2(DEPTH);

    logic             bank_re    [NUM_BANKS];
    logic [ROW_W-1:0] bank_raddr [NUM_BANKS];
    logic             bank_we    [NUM_BANKS];
    logic [ROW_W-1:0] bank_waddr [NUM_BANKS];
    wmask_t           bank_wmask [NUM_BANKS];
    word_t            bank_wdata [NUM_BANKS];
    word_t            bank_rdata [NUM_BANKS];

    logic              load_accept [NUM_LOADS];
    logic [BANK_W-1:0] load_bank   [NUM_LOADS];

    bank_arbiter #(
        .NUM_BANKS (NUM_BANKS),
        .NUM_LOADS (NUM_LOADS)
    ) u_arbiter (
        .fill_req    (fill_req),
        .store_req   (store_req),
        .load_req    (load_req),
        .fill_ready  (fill_ready),
        .store_ready (store_ready),
        .load_ready  (load_ready),
        .bank_re     (bank_re),
        .bank_raddr  (bank_raddr),
        .bank_we     (bank_we),
        .bank_waddr  (bank_waddr),
        .bank_wmask  (bank_wmask),
        .bank_wdata  (bank_wdata),
        .load_accept (load_accept),
        .load_bank   (load_bank)
    );

    // One read port for loads, one write port for fill and store.
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        sram_bank #(
            .DEPTH (DEPTH)
        ) u_bank (
            .clk   (clk),
            .re    (bank_re[b]),
            .raddr (bank_raddr[b]),
            .rdata (bank_rdata[b]),
            .we    (bank_we[b]),
            .waddr (bank_waddr[b]),
            .wmask (bank_wmask[b]),
            .wdata (bank_wdata[b])
        );
    end

    load_align #(
        .NUM_BANKS (NUM_BANKS),
        .NUM_LOADS (NUM_LOADS)
    ) u_align (
        .clk         (clk),
        .reset       (reset),
        .load_accept (load_accept),
        .load_bank   (load_bank),
        .bank_rdata  (bank_rdata),
        .load_rdata  (load_rdata),
        .load_rvalid (load_rvalid)
    );

    mmio_regs u_mmio (
        .clk       (clk),
        .reset     (reset),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .power_off (power_off),
        .reboot    (reboot)
    );

endmodule

//--- test/soc_memory_assertions.sv
`timescale 1ns/1ps

module soc_memory_assertions (
    input logic                clk,
    input logic                reset,
    input logic                bvalid,
    input logic                bready,
    input soc_pkg::axil_resp_t bresp,
    input logic                rvalid,
    input logic                rready,
    input soc_pkg::word_t      rdata,
    input soc_pkg::axil_resp_t rresp,
    input logic                reboot
);

    // Number of assertion failures so far.
    int error_count = 0;

    // A held response stays valid and unchanged until it is taken.
    b_held: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else begin
            $error("write response dropped or changed before bready");
            error_count++;
        end

    r_held: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else begin
            $error("read response dropped or changed before rready");
            error_count++;
        end

    reboot_pulse: assert property (@(posedge clk) disable iff (reset)
        reboot |=> !reboot)
        else begin
            $error("reboot high for more than one cycle");
            error_count++;
        end

    reset_idle: assert property (@(posedge clk) reset |=> !bvalid && !rvalid)
        else begin
            $error("response valid set right after reset");
            error_count++;
        end

endmodule

bind mmio_regs soc_memory_assertions u_assertions (
    .clk    (clk),
    .reset  (reset),
    .bvalid (bvalid),
    .bready (bready),
    .bresp  (bresp),
    .rvalid (rvalid),
    .rready (rready),
    .rdata  (rdata),
    .rresp  (rresp),
    .reboot (reboot)
);

//--- test/soc_memory_tb.sv
`timescale 1ns/1ps

module soc_memory_tb;
    import soc_pkg::*;

    localparam int NUM_BANKS     = 2;
    localparam int NUM_LOADS     = 2;
    localparam int BANK_W        = $clog2(NUM_BANKS);
    // Random traffic stays in a small window so loads often hit freshly written rows.
    localparam int AREA          = 64;
    localparam int RANDOM_CYCLES = 200;
    // Upper bound on the length of all phases together.
    localparam int TEST_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

    logic       clk;
    logic       reset;
    cache_req_t fill_req;
    logic       fill_ready;
    cache_req_t store_req;
    logic       store_ready;
    cache_req_t load_req    [NUM_LOADS];
    logic       load_ready  [NUM_LOADS];
    word_t      load_rdata  [NUM_LOADS];
    logic       load_rvalid [NUM_LOADS];

    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    wmask_t     wstrb;
    logic       wvalid;
    logic       wready;
    axil_resp_t bresp;
    logic       bvalid;
    logic       bready;
    axil_addr_t araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    axil_resp_t rresp;
    logic       rvalid;
    logic       rready;
    logic       power_off;
    logic       reboot;

    // Reference state.
    word_t      model [1 << WADDR_W];
    cache_req_t next_fill;
    cache_req_t next_store;
    cache_req_t next_load  [NUM_LOADS];
    logic       exp_valid  [NUM_LOADS];
    word_t      exp_data   [NUM_LOADS];
    logic       load_taken [NUM_LOADS];
    logic       store_taken;
    word_t      scratch_model;
    integer     seed;
    int         cycle_count = 0;

    soc_memory #(
        .NUM_BANKS (NUM_BANKS),
        .NUM_LOADS (NUM_LOADS)
    ) u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // The bound register block checker counts its failed assertions.
    always @(negedge clk) begin
        if (u_dut.u_mmio.u_assertions.error_count != 0) begin
            $display("An assertion on the register block failed");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic cache_req_t make_req(logic en, logic we, wmask_t mask, int addr,
                                            word_t data);
        cache_req_t r;
        r.en    = en;
        r.we    = we;
        r.wmask = mask;
        r.addr  = waddr_t'(addr);
        r.data  = data;
        return r;
    endfunction

    // Each row starts with a word built from its full address.
    function automatic word_t init_word(int addr);
        waddr_t a;
        a = waddr_t'(addr);
        return {a, 6'h2a, ~a, 6'h15};
    endfunction

    function automatic cache_req_t random_req(logic write);
        cache_req_t r;
        r.en    = ({$random(seed)} % 4) != 0;
        r.we    = write;
        r.wmask = write ? wmask_t'($random(seed)) : '0;
        r.addr  = waddr_t'({$random(seed)} % AREA);
        r.data  = $random(seed);
        return r;
    endfunction

    task automatic write_model(cache_req_t r);
        for (int b = 0; b < 4; b++) begin
            if (r.wmask[b]) begin
                model[r.addr][8*b +: 8] = r.data[8*b +: 8];
            end
        end
    endtask

    // Runs at the falling edge, when this cycle's requests and last cycle's
    // load results are both stable.
    task automatic check_cycle();
        logic [NUM_BANKS-1:0] claimed;
        logic [BANK_W-1:0]    bank;
        logic                 store_ok;
        claimed = '0;
        for (int l = 0; l < NUM_LOADS; l++) begin
            check_value($sformatf("load_rvalid[%0d]", l), exp_valid[l], load_rvalid[l]);
            if (exp_valid[l]) begin
                check_value($sformatf("load_rdata[%0d]", l), exp_data[l], load_rdata[l]);
            end
        end
        check_value("fill_ready", 1'b1, fill_ready);
        store_ok = !(fill_req.en && fill_req.we &&
                     fill_req.addr[BANK_W-1:0] == store_req.addr[BANK_W-1:0]);
        check_value("store_ready", store_ok, store_ready);

        // Loads see memory as it was before this cycle's writes.
        for (int l = 0; l < NUM_LOADS; l++) begin
            bank = load_req[l].addr[BANK_W-1:0];
            check_value($sformatf("load_ready[%0d]", l), !claimed[bank], load_ready[l]);
            load_taken[l] = load_req[l].en && !claimed[bank];
            exp_valid[l]  = load_taken[l];
            if (load_taken[l]) begin
                exp_data[l]   = model[load_req[l].addr];
                claimed[bank] = 1'b1;
            end
        end
        store_taken = store_req.en && store_req.we && store_ok;
        if (store_taken) begin
            write_model(store_req);
        end
        if (fill_req.en && fill_req.we) begin
            write_model(fill_req);
        end
    endtask

    task automatic step();
        @(posedge clk);
        fill_req  <= next_fill;
        store_req <= next_store;
        for (int l = 0; l < NUM_LOADS; l++) begin
            load_req[l] <= next_load[l];
        end
        @(negedge clk);
        check_cycle();
    endtask

    task automatic idle_requests();
        next_fill  = '0;
        next_store = '0;
        for (int l = 0; l < NUM_LOADS; l++) begin
            next_load[l] = '0;
        end
    endtask

    task automatic axi_write(axil_addr_t addr, word_t data, wmask_t strb,
                             output axil_resp_t resp);
        int   delay;
        logic exp_reboot;
        exp_reboot = addr == REG_CTRL_ADDR && strb[0] && data[CTRL_REBOOT_BIT];
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        check_value("bvalid", 1'b1, bvalid);
        check_value("awready", 1'b0, awready);
        check_value("wready", 1'b0, wready);
        check_value("reboot", exp_reboot, reboot);
        @(negedge clk);
        check_value("reboot", 1'b0, reboot);
        // Response must be held while bready stays low.
        delay = {$random(seed)} % 3;
        repeat (delay) begin
            check_value("bvalid", 1'b1, bvalid);
            @(negedge clk);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        check_value("bvalid", 1'b1, bvalid);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axi_read(axil_addr_t addr, output word_t data, output axil_resp_t resp);
        int delay;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        delay = {$random(seed)} % 4;
        repeat (delay) begin
            @(negedge clk);
            check_value("rvalid", 1'b1, rvalid);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(negedge clk);
        check_value("rvalid", 1'b1, rvalid);
        // No new read address is taken while a response is held.
        check_value("arready", 1'b0, arready);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    initial begin
        axil_resp_t resp;
        word_t      data;
        word_t      rd;
        wmask_t     strb;
        axil_addr_t addr;

        seed      = 32'h15ce;
        reset     = 1'b1;
        fill_req  = '0;
        store_req = '0;
        for (int l = 0; l < NUM_LOADS; l++) begin
            load_req[l]   = '0;
            exp_valid[l]  = 1'b0;
            load_taken[l] = 1'b0;
        end
        awaddr        = '0;
        awvalid       = 1'b0;
        wdata         = '0;
        wstrb         = '0;
        wvalid        = 1'b0;
        bready        = 1'b0;
        araddr        = '0;
        arvalid       = 1'b0;
        rready        = 1'b0;
        store_taken   = 1'b0;
        scratch_model = '0;
        idle_requests();

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        for (int l = 0; l < NUM_LOADS; l++) begin
            check_value($sformatf("load_rvalid[%0d]", l), 1'b0, load_rvalid[l]);
        end
        check_value("bvalid", 1'b0, bvalid);
        check_value("rvalid", 1'b0, rvalid);
        check_value("power_off", 1'b0, power_off);
        check_value("reboot", 1'b0, reboot);

        // Known contents in the test window.
        for (int a = 0; a < AREA; a++) begin
            next_fill = make_req(1'b1, 1'b1, 4'hF, a, init_word(a));
            step();
        end

        // Two loads on bank 0; port 1 waits a cycle.
        idle_requests();
        next_load[0] = make_req(1'b1, 1'b0, '0, 4, '0);
        next_load[1] = make_req(1'b1, 1'b0, '0, 6, '0);
        step();
        check_value("load_ready[1]", 1'b0, load_ready[1]);
        next_load[0] = '0;
        step();

        // Fill and store on bank 0 together; the store lands only after its retry.
        idle_requests();
        next_fill    = make_req(1'b1, 1'b1, 4'hF, 8, 32'h1234_5678);
        next_store   = make_req(1'b1, 1'b1, 4'h3, 10, 32'hdead_beef);
        next_load[0] = make_req(1'b1, 1'b0, '0, 10, '0);
        step();
        check_value("store_ready", 1'b0, store_ready);
        next_fill = '0;
        step();
        check_value("store_ready", 1'b1, store_ready);
        next_store = '0;
        step();

        // Every request on its own port of its own bank.
        next_fill    = make_req(1'b1, 1'b1, 4'hF, 12, 32'h0bad_cafe);
        next_store   = make_req(1'b1, 1'b1, 4'hC, 15, 32'h5a5a_a5a5);
        next_load[0] = make_req(1'b1, 1'b0, '0, 16, '0);
        next_load[1] = make_req(1'b1, 1'b0, '0, 17, '0);
        step();
        check_value("store_ready", 1'b1, store_ready);
        check_value("load_ready[1]", 1'b1, load_ready[1]);

        // Back-to-back loads on port 0.
        idle_requests();
        for (int i = 0; i < 8; i++) begin
            next_load[0] = make_req(1'b1, 1'b0, '0, 20 + i, '0);
            step();
        end
        idle_requests();
        step();

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            next_fill = random_req(1'b1);
            // A refused store or load is offered again unchanged.
            if (!next_store.en || store_taken) begin
                next_store = random_req(1'b1);
            end
            for (int l = 0; l < NUM_LOADS; l++) begin
                if (!next_load[l].en || load_taken[l]) begin
                    next_load[l] = random_req(1'b0);
                end
            end
            step();
        end
        idle_requests();
        step();
        step();

        // Scratch register under random strobes.
        for (int i = 0; i < 20; i++) begin
            data = $random(seed);
            strb = wmask_t'($random(seed));
            axi_write(REG_SCRATCH_ADDR, data, strb, resp);
            check_value("bresp", RESP_OKAY, resp);
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    scratch_model[8*b +: 8] = data[8*b +: 8];
                end
            end
            axi_read(REG_SCRATCH_ADDR, rd, resp);
            check_value("rresp", RESP_OKAY, resp);
            check_value("rdata", scratch_model, rd);
        end

        // Unmapped offsets.
        for (int i = 0; i < 6; i++) begin
            addr = axil_addr_t'($random(seed));
            if (addr == REG_CTRL_ADDR || addr == REG_SCRATCH_ADDR) begin
                addr = 4'hC;
            end
            axi_write(addr, 32'hffff_ffff, 4'hF, resp);
            check_value("bresp", RESP_SLVERR, resp);
            axi_read(addr, rd, resp);
            check_value("rresp", RESP_SLVERR, resp);
            check_value("rdata", 32'h0, rd);
            check_value("power_off", 1'b0, power_off);
            axi_read(REG_SCRATCH_ADDR, rd, resp);
            check_value("rdata", scratch_model, rd);
        end

        // Reboot pulse, then sticky power-off.
        axi_write(REG_CTRL_ADDR, 32'h2, 4'hF, resp);
        check_value("bresp", RESP_OKAY, resp);
        check_value("power_off", 1'b0, power_off);
        axi_read(REG_CTRL_ADDR, rd, resp);
        check_value("rdata", 32'h0, rd);
        axi_write(REG_CTRL_ADDR, 32'h1, 4'hF, resp);
        check_value("power_off", 1'b1, power_off);
        axi_read(REG_CTRL_ADDR, rd, resp);
        check_value("rdata", 32'h1, rd);
        axi_write(REG_CTRL_ADDR, 32'h0, 4'hF, resp);
        check_value("power_off", 1'b1, power_off);
        axi_read(REG_CTRL_ADDR, rd, resp);
        check_value("rdata", 32'h1, rd);

        @(negedge clk);
        if (u_dut.u_mmio.u_assertions.error_count != 0) begin
            $display("An assertion on the register block failed");
            $display("Test failed");
            $fatal(1, "assertion failure");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- sources.f
hw/soc_pkg.sv
hw/sram_bank.sv
hw/bank_arbiter.sv
hw/load_align.sv
hw/mmio_regs.sv
hw/soc_memory.sv
test/soc_memory_assertions.sv
test/soc_memory_tb.sv

//--- Bender.yml
package:
  name: soc_memory

sources:
  - hw/soc_pkg.sv
  - hw/sram_bank.sv
  - hw/bank_arbiter.sv
  - hw/load_align.sv
  - hw/mmio_regs.sv
  - hw/soc_memory.sv
  - target: test
    files:
      - test/soc_memory_assertions.sv
      - test/soc_memory_tb.sv
